//--- hdl/gnn_graph_pkg.sv
package gnn_graph_pkg;

    // node addressing
    localparam int NODE_ID_W = 7;

    // neighbor-ID SRAM beat layout
    localparam int IDS_PER_BEAT   = 9;
    localparam int MAX_DEGREE_DEF = 27;  // three beats

    // count has to reach MAX_DEGREE_DEF itself
    localparam int NBR_COUNT_W = $clog2(MAX_DEGREE_DEF + 1);

    typedef logic [NODE_ID_W-1:0] node_id_t;

    // entry k at bits 7k+6:7k, entry 0 lowest
    typedef node_id_t [IDS_PER_BEAT-1:0] nbr_beat_t;

    typedef logic [NBR_COUNT_W-1:0] nbr_count_t;

endpackage

//--- hdl/edge_pe_bus_pkg.sv
package edge_pe_bus_pkg;

    // feature vector beat, lane 0 in the low bits
    localparam int FV_LANES  = 4;
    localparam int FV_LANE_W = 16;

    typedef logic [FV_LANES-1:0][FV_LANE_W-1:0] fv_beat_t;

    // shared bus arbiter
    localparam int NUM_EDGE_PE = 4;

    typedef logic [$clog2(NUM_EDGE_PE)-1:0] pe_tag_t;

    typedef enum logic {
        NBR_ID = 1'b0,  // neighbor list
        NBR_FV = 1'b1   // feature vector
    } req_kind_t;

endpackage

//--- hdl/nbr_list_if.sv
`timescale 1ns/1ps

interface nbr_list_if;

    logic                      capture_en;  // controller waits for the list
    gnn_graph_pkg::nbr_count_t rd_idx;
    logic                      list_done;   // one cycle after the eos beat
    gnn_graph_pkg::nbr_count_t count;
    gnn_graph_pkg::node_id_t   rd_id;

    modport ctrl (
        output capture_en,
        output rd_idx,
        input  list_done,
        input  count,
        input  rd_id
    );

    modport buffer (
        input  capture_en,
        input  rd_idx,
        output list_done,
        output count,
        output rd_id
    );

endinterface

//--- hdl/neighbor_id_buffer.sv
`timescale 1ns/1ps

module neighbor_id_buffer #(
    parameter int MAX_DEGREE = gnn_graph_pkg::MAX_DEGREE_DEF
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      nid_valid,
    input  logic                      nid_sos,
    input  logic                      nid_eos,
    input  gnn_graph_pkg::nbr_count_t nid_count,
    input  gnn_graph_pkg::nbr_beat_t  nid_beat,
    nbr_list_if.buffer                nbr
);

    gnn_graph_pkg::node_id_t   slots [MAX_DEGREE];
    gnn_graph_pkg::nbr_count_t wr_off;
    gnn_graph_pkg::nbr_count_t base;
    gnn_graph_pkg::nbr_count_t count_q;
    logic                      list_done_q;
    logic                      take;

    assign take = nbr.capture_en && nid_valid;
    assign base = nid_sos ? '0 : wr_off;  // a new list starts at slot 0

    // unpack nine ids per beat, lowest entry into the lowest slot
    always_ff @(posedge clk) begin
        if (take) begin
            for (int k = 0; k < gnn_graph_pkg::IDS_PER_BEAT; k++) begin
                if (int'(base) + k < MAX_DEGREE) begin
                    slots[int'(base) + k] <= nid_beat[k];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_off      <= '0;
            count_q     <= '0;
            list_done_q <= 1'b0;
        end else begin
            list_done_q <= take && nid_eos;
            if (take) begin
                wr_off <= base + gnn_graph_pkg::nbr_count_t'(gnn_graph_pkg::IDS_PER_BEAT);
                if (nid_sos) begin
                    count_q <= nid_count;  // count rides on the first beat
                end
            end
        end
    end

    assign nbr.list_done = list_done_q;
    assign nbr.count     = count_q;
    assign nbr.rd_id     = slots[nbr.rd_idx];

endmodule

//--- hdl/fv_bank_stage.sv
`timescale 1ns/1ps

module fv_bank_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      fwd_en,
    input  gnn_graph_pkg::node_id_t   target,
    input  logic                      fv_valid,
    input  logic                      fv_sos,
    input  logic                      fv_eos,
    input  edge_pe_bus_pkg::fv_beat_t fv_data,
    output logic                      bank_valid,
    output logic                      bank_sos,
    output logic                      bank_eos,
    output edge_pe_bus_pkg::fv_beat_t bank_fv,
    output gnn_graph_pkg::node_id_t   bank_node_id
);

    logic take;

    assign take = fwd_en && fv_valid;

    // framing follows the beat, low between beats
    always_ff @(posedge clk) begin
        if (reset) begin
            bank_valid <= 1'b0;
            bank_sos   <= 1'b0;
            bank_eos   <= 1'b0;
        end else begin
            bank_valid <= take;
            bank_sos   <= take && fv_sos;
            bank_eos   <= take && fv_eos;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            bank_fv      <= fv_data;
            bank_node_id <= target;  // every beat tagged with the target node
        end
    end

endmodule

//--- hdl/edge_pe_ctrl.sv
`timescale 1ns/1ps

module edge_pe_ctrl (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       task_valid,
    input  gnn_graph_pkg::node_id_t    task_node_id,
    output logic                       idle,
    output logic                       arb_req,
    output edge_pe_bus_pkg::req_kind_t arb_kind,
    output gnn_graph_pkg::node_id_t    arb_node_id,
    input  logic                       arb_grant,
    input  logic                       fv_valid,
    input  logic                       fv_eos,
    nbr_list_if.ctrl                   nbr,
    output logic                       fwd_en,
    output gnn_graph_pkg::node_id_t    target,
    output logic                       done_aggr
);

    typedef enum logic [2:0] {
        IDLE,
        REQ_LIST,
        WAIT_LIST,
        REQ_FV,
        WAIT_FV,
        COMPLETE
    } state_t;

    state_t                    state;
    state_t                    state_nx;
    gnn_graph_pkg::node_id_t   target_q;
    gnn_graph_pkg::nbr_count_t fv_ptr;
    gnn_graph_pkg::nbr_count_t fv_ptr_inc;
    logic                      task_start;
    logic                      fv_last;

    assign task_start = (state == IDLE) && task_valid;
    assign fv_last    = fv_valid && fv_eos;
    assign fv_ptr_inc = fv_ptr + gnn_graph_pkg::nbr_count_t'(1);

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: begin
                if (task_valid) begin
                    state_nx = REQ_LIST;
                end
            end
            REQ_LIST: begin
                if (arb_grant) begin
                    state_nx = WAIT_LIST;
                end
            end
            WAIT_LIST: begin
                if (nbr.list_done) begin
                    // empty list skips the feature fetch
                    state_nx = (nbr.count == '0) ? COMPLETE : REQ_FV;
                end
            end
            REQ_FV: begin
                if (arb_grant) begin
                    state_nx = WAIT_FV;
                end
            end
            WAIT_FV: begin
                if (fv_last) begin
                    state_nx = (fv_ptr_inc == nbr.count) ? COMPLETE : REQ_FV;
                end
            end
            COMPLETE: state_nx = IDLE;
            default:  state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= IDLE;
            fv_ptr <= '0;
        end else begin
            state <= state_nx;
            if (task_start) begin
                fv_ptr <= '0;
            end else if (state == WAIT_FV && fv_last) begin
                fv_ptr <= fv_ptr_inc;  // next neighbor
            end
        end
    end

    always_ff @(posedge clk) begin
        if (task_start) begin
            target_q <= task_node_id;
        end
    end

    // request held until the grant cycle
    always_comb begin
        arb_req     = 1'b0;
        arb_kind    = edge_pe_bus_pkg::NBR_ID;
        arb_node_id = '0;
        case (state)
            REQ_LIST: begin
                arb_req     = 1'b1;
                arb_node_id = target_q;
            end
            REQ_FV: begin
                arb_req     = 1'b1;
                arb_kind    = edge_pe_bus_pkg::NBR_FV;
                arb_node_id = nbr.rd_id;
            end
            default: begin
                arb_req = 1'b0;
            end
        endcase
    end

    assign idle           = (state == IDLE);
    assign nbr.capture_en = (state == WAIT_LIST);
    assign nbr.rd_idx     = fv_ptr;
    assign fwd_en         = (state == WAIT_FV);
    assign target         = target_q;
    assign done_aggr      = (state == COMPLETE);  // lines up with the last bank beat

endmodule

//--- hdl/edge_pe_top.sv
`timescale 1ns/1ps

module edge_pe_top #(
    parameter edge_pe_bus_pkg::pe_tag_t PE_TAG = '0,
    parameter int MAX_DEGREE = gnn_graph_pkg::MAX_DEGREE_DEF
) (
    input  logic                       clk,
    input  logic                       reset,

    // task from dispatch
    input  logic                       task_valid,
    input  gnn_graph_pkg::node_id_t    task_node_id,
    output logic                       idle,

    // shared bus arbiter
    output logic                       arb_req,
    output edge_pe_bus_pkg::req_kind_t arb_kind,
    output gnn_graph_pkg::node_id_t    arb_node_id,
    output edge_pe_bus_pkg::pe_tag_t   arb_pe_tag,
    input  logic                       arb_grant,

    // neighbor-ID SRAM stream
    input  logic                       nid_valid,
    input  logic                       nid_sos,
    input  logic                       nid_eos,
    input  gnn_graph_pkg::nbr_count_t  nid_count,
    input  gnn_graph_pkg::nbr_beat_t   nid_beat,

    // feature SRAM stream
    input  logic                       fv_valid,
    input  logic                       fv_sos,
    input  logic                       fv_eos,
    input  edge_pe_bus_pkg::fv_beat_t  fv_data,

    // aggregation bank
    output logic                       bank_valid,
    output logic                       bank_sos,
    output logic                       bank_eos,
    output edge_pe_bus_pkg::fv_beat_t  bank_fv,
    output gnn_graph_pkg::node_id_t    bank_node_id,
    output logic                       done_aggr
);

    logic                    fwd_en;
    gnn_graph_pkg::node_id_t target;

    nbr_list_if nbr_i ();

    assign arb_pe_tag = PE_TAG;

    edge_pe_ctrl ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .task_valid   (task_valid),
        .task_node_id (task_node_id),
        .idle         (idle),
        .arb_req      (arb_req),
        .arb_kind     (arb_kind),
        .arb_node_id  (arb_node_id),
        .arb_grant    (arb_grant),
        .fv_valid     (fv_valid),
        .fv_eos       (fv_eos),
        .nbr          (nbr_i.ctrl),
        .fwd_en       (fwd_en),
        .target       (target),
        .done_aggr    (done_aggr)
    );

    neighbor_id_buffer #(
        .MAX_DEGREE (MAX_DEGREE)
    ) nbr_buf_i (
        .clk       (clk),
        .reset     (reset),
        .nid_valid (nid_valid),
        .nid_sos   (nid_sos),
        .nid_eos   (nid_eos),
        .nid_count (nid_count),
        .nid_beat  (nid_beat),
        .nbr       (nbr_i.buffer)
    );

    fv_bank_stage fv_stage_i (
        .clk          (clk),
        .reset        (reset),
        .fwd_en       (fwd_en),
        .target       (target),
        .fv_valid     (fv_valid),
        .fv_sos       (fv_sos),
        .fv_eos       (fv_eos),
        .fv_data      (fv_data),
        .bank_valid   (bank_valid),
        .bank_sos     (bank_sos),
        .bank_eos     (bank_eos),
        .bank_fv      (bank_fv),
        .bank_node_id (bank_node_id)
    );

endmodule

//--- tb/edge_pe_tb.sv
`timescale 1ns/1ps

module edge_pe_tb;

    localparam int NUM_TASKS   = 20;
    localparam int CYCLE_LIMIT = NUM_TASKS * 300;
    localparam int MAX_DEG     = gnn_graph_pkg::MAX_DEGREE_DEF;
    localparam edge_pe_bus_pkg::pe_tag_t TAG = 2'd2;

    typedef struct packed {
        logic                      sos;
        logic                      eos;
        gnn_graph_pkg::node_id_t   node;
        edge_pe_bus_pkg::fv_beat_t fv;
    } bank_beat_t;

    logic                       clk = 1'b0;
    logic                       reset;
    logic                       task_valid;
    gnn_graph_pkg::node_id_t    task_node_id;
    logic                       idle;
    logic                       arb_req;
    edge_pe_bus_pkg::req_kind_t arb_kind;
    gnn_graph_pkg::node_id_t    arb_node_id;
    edge_pe_bus_pkg::pe_tag_t   arb_pe_tag;
    logic                       arb_grant;
    logic                       nid_valid;
    logic                       nid_sos;
    logic                       nid_eos;
    gnn_graph_pkg::nbr_count_t  nid_count;
    gnn_graph_pkg::nbr_beat_t   nid_beat;
    logic                       fv_valid;
    logic                       fv_sos;
    logic                       fv_eos;
    edge_pe_bus_pkg::fv_beat_t  fv_data;
    logic                       bank_valid;
    logic                       bank_sos;
    logic                       bank_eos;
    edge_pe_bus_pkg::fv_beat_t  bank_fv;
    gnn_graph_pkg::node_id_t    bank_node_id;
    logic                       done_aggr;

    // current task as seen by the SRAM models and the checker
    gnn_graph_pkg::node_id_t    cur_target;
    int                         cur_count;
    gnn_graph_pkg::node_id_t    nbr_list [MAX_DEG];
    edge_pe_bus_pkg::fv_beat_t  feat [MAX_DEG][3];
    int                         feat_len [MAX_DEG];
    int                         fv_n;  // neighbor of the beat on the fv inputs
    int                         fv_b;

    logic [31:0] lcg_state = 32'h668b_5663;
    int          cycles = 0;
    int          req_idx = 0;
    logic        exp_valid = 1'b0;
    bank_beat_t  exp_beat;
    logic        done_d1 = 1'b0;
    logic        done_d2 = 1'b0;

    always #4 clk = ~clk;

    edge_pe_top #(
        .PE_TAG     (TAG),
        .MAX_DEGREE (MAX_DEG)
    ) dut_i (
        .clk          (clk),
        .reset        (reset),
        .task_valid   (task_valid),
        .task_node_id (task_node_id),
        .idle         (idle),
        .arb_req      (arb_req),
        .arb_kind     (arb_kind),
        .arb_node_id  (arb_node_id),
        .arb_pe_tag   (arb_pe_tag),
        .arb_grant    (arb_grant),
        .nid_valid    (nid_valid),
        .nid_sos      (nid_sos),
        .nid_eos      (nid_eos),
        .nid_count    (nid_count),
        .nid_beat     (nid_beat),
        .fv_valid     (fv_valid),
        .fv_sos       (fv_sos),
        .fv_eos       (fv_eos),
        .fv_data      (fv_data),
        .bank_valid   (bank_valid),
        .bank_sos     (bank_sos),
        .bank_eos     (bank_eos),
        .bank_fv      (bank_fv),
        .bank_node_id (bank_node_id),
        .done_aggr    (done_aggr)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(int n);
        return int'((lcg_next() >> 8) % n);
    endfunction

    // request idx of the task as {kind, node id}
    function automatic logic [7:0] ref_request(int idx);
        if (idx == 0) begin
            return {1'b0, cur_target};  // list request first
        end
        return {1'b1, nbr_list[idx-1]};
    endfunction

    function automatic bank_beat_t ref_bank(int n, int b);
        bank_beat_t r;
        r.sos  = (b == 0);
        r.eos  = (b == feat_len[n] - 1);
        r.node = cur_target;
        r.fv   = feat[n][b];
        return r;
    endfunction

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            $display("Finished with errors");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "timeout");
        end
    end

    // sampled at the rising edge before any register updates
    always @(posedge clk) begin : compare
        logic [7:0] req;
        if (!reset) begin
            check("bank_valid", bank_valid, exp_valid);
            if (exp_valid) begin
                check("bank_sos", bank_sos, exp_beat.sos);
                check("bank_eos", bank_eos, exp_beat.eos);
                check("bank_node_id", bank_node_id, exp_beat.node);
                check("bank_fv", bank_fv, exp_beat.fv);
            end
            if (arb_req && arb_grant) begin
                req = ref_request(req_idx);
                check("arb_kind", arb_kind, req[7]);
                check("arb_node_id", arb_node_id, req[6:0]);
                req_idx++;
            end
            check("done_aggr", done_aggr, done_d1);
            if (done_aggr) begin
                check("request count", req_idx, cur_count + 1);
                req_idx = 0;
            end
            done_d1   = done_d2 || (fv_valid && fv_eos && fv_n == cur_count - 1);
            done_d2   = nid_valid && nid_eos && cur_count == 0;  // empty list
            exp_valid = fv_valid;
            if (fv_valid) begin
                exp_beat = ref_bank(fv_n, fv_b);
            end
        end
    end

    task automatic make_task(int t);
        int fixed [7] = '{0, 1, 9, 10, 18, 19, 27};  // list length edges
        cur_target = gnn_graph_pkg::node_id_t'(lcg_next() >> 16);
        cur_count  = (t < 7) ? fixed[t] : rand_below(MAX_DEG + 1);
        for (int n = 0; n < MAX_DEG; n++) begin
            nbr_list[n] = gnn_graph_pkg::node_id_t'(lcg_next() >> 12);
            feat_len[n] = 1 + rand_below(3);
            for (int b = 0; b < 3; b++) begin
                feat[n][b] = {lcg_next(), lcg_next()};
            end
        end
    endtask

    // arbiter model returns at the falling edge after the grant cycle
    task automatic grant_request();
        int delay;
        while (!arb_req) @(negedge clk);
        delay = rand_below(4);
        repeat (delay) @(negedge clk);
        arb_grant = 1'b1;
        @(negedge clk);
        arb_grant = 1'b0;
    endtask

    task automatic send_list();
        int beats;
        beats = (cur_count == 0) ? 1 : (cur_count + 8) / 9;
        task_valid   = 1'b1;  // must be ignored while busy
        task_node_id = ~cur_target;
        @(negedge clk);
        task_valid = 1'b0;
        for (int b = 0; b < beats; b++) begin
            if (b > 0 && rand_below(4) == 0) begin
                nid_valid = 1'b0;  // bubble
                @(negedge clk);
            end
            nid_valid = 1'b1;
            nid_sos   = (b == 0);
            nid_eos   = (b == beats - 1);
            nid_count = gnn_graph_pkg::nbr_count_t'(cur_count);
            for (int k = 0; k < gnn_graph_pkg::IDS_PER_BEAT; k++) begin
                if (b * 9 + k < cur_count) begin
                    nid_beat[k] = nbr_list[b * 9 + k];
                end else begin
                    nid_beat[k] = gnn_graph_pkg::node_id_t'(lcg_next() >> 20);
                end
            end
            @(negedge clk);
        end
        nid_valid = 1'b0;
        nid_sos   = 1'b0;
        nid_eos   = 1'b0;
    endtask

    task automatic send_features(int n);
        @(negedge clk);  // SRAM answers two cycles after the grant
        for (int b = 0; b < feat_len[n]; b++) begin
            if (b > 0 && rand_below(4) == 0) begin
                fv_valid = 1'b0;
                @(negedge clk);
            end
            fv_valid = 1'b1;
            fv_sos   = (b == 0);
            fv_eos   = (b == feat_len[n] - 1);
            fv_data  = feat[n][b];
            fv_n     = n;
            fv_b     = b;
            @(negedge clk);
        end
        fv_valid = 1'b0;
        fv_sos   = 1'b0;
        fv_eos   = 1'b0;
    endtask

    task automatic run_task();
        task_valid   = 1'b1;
        task_node_id = cur_target;
        @(negedge clk);
        task_valid   = 1'b0;
        task_node_id = '0;
        check("idle", idle, 1'b0);
        grant_request();
        send_list();
        for (int n = 0; n < cur_count; n++) begin
            grant_request();
            send_features(n);
        end
        while (!done_aggr) @(negedge clk);
        @(negedge clk);
        check("idle", idle, 1'b1);
    endtask

    initial begin
        reset        = 1'b1;
        task_valid   = 1'b0;
        task_node_id = '0;
        arb_grant    = 1'b0;
        nid_valid    = 1'b0;
        nid_sos      = 1'b0;
        nid_eos      = 1'b0;
        nid_count    = '0;
        nid_beat     = '0;
        fv_valid     = 1'b0;
        fv_sos       = 1'b0;
        fv_eos       = 1'b0;
        fv_data      = '0;
        fv_n         = 0;
        fv_b         = 0;
        cur_target   = '0;
        cur_count    = 0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        check("idle", idle, 1'b1);
        check("arb_req", arb_req, 1'b0);
        check("bank_valid", bank_valid, 1'b0);
        check("done_aggr", done_aggr, 1'b0);
        check("arb_pe_tag", arb_pe_tag, TAG);
        for (int t = 0; t < NUM_TASKS; t++) begin
            make_task(t);
            run_task();
        end
        @(negedge clk);
        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- sources.f
hdl/gnn_graph_pkg.sv
hdl/edge_pe_bus_pkg.sv
hdl/nbr_list_if.sv
hdl/neighbor_id_buffer.sv
hdl/fv_bank_stage.sv
hdl/edge_pe_ctrl.sv
hdl/edge_pe_top.sv
tb/edge_pe_tb.sv
